/* id_range_pkg.sv */
`default_nettype none

package id_range_pkg;

    // widths of the scanner datapath
    localparam int ID_W       = 40;
    localparam int MAX_DIGITS = 13;
    localparam int SUM_W      = 64;
    localparam int COUNT_W    = 40;
    localparam int NDIG_W     = 4;
    // the converter counts up to ID_W shifts
    localparam int BIT_CNT_W  = $clog2(ID_W + 1);

    typedef logic [ID_W-1:0] id_t;
    typedef logic [3:0]      digit_t;

    // digit 0 is the least significant decimal digit
    typedef digit_t [MAX_DIGITS-1:0] bcd_t;

    typedef struct packed {
        id_t lo;
        id_t hi;
    } range_t;

    // one slot of the walk holds the number in binary and decimal at once
    typedef struct packed {
        logic valid;
        logic last;
        id_t  value;
        bcd_t digits;
    } candidate_t;

    typedef struct packed {
        logic valid;
        logic last;
        logic invalid;
        id_t  value;
    } verdict_t;

endpackage

`default_nettype wire

/* bin_to_bcd.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_to_bcd
    import id_range_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic conv_start,
    input  id_t  conv_value,
    output logic conv_done,
    output bcd_t conv_digits
);

    logic                 active;
    logic [BIT_CNT_W-1:0] bit_cnt;
    id_t                  shift_bin;
    bcd_t                 bcd;

    // one double-dabble step corrects every digit of five or more and then shifts in a bit
    function automatic bcd_t dabble_step(input bcd_t d, input logic bit_in);
        bcd_t                    adj;
        logic [$bits(bcd_t)-1:0] flat;
        adj = d;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            if (d[i] >= 4'd5) begin
                adj[i] = d[i] + 4'd3;
            end
        end
        flat = adj;
        return {flat[$bits(bcd_t)-2:0], bit_in};
    endfunction

    // the first shift happens on the load edge, so ID_W edges cover every bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active    <= 1'b0;
            bit_cnt   <= '0;
            conv_done <= 1'b0;
        end else begin
            conv_done <= 1'b0;
            if (conv_start) begin
                active  <= 1'b1;
                bit_cnt <= BIT_CNT_W'(1);
            end else if (active) begin
                bit_cnt <= bit_cnt + BIT_CNT_W'(1);
                if (bit_cnt == BIT_CNT_W'(ID_W - 1)) begin
                    active    <= 1'b0;
                    conv_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (conv_start) begin
            shift_bin <= conv_value << 1;
            bcd       <= dabble_step('0, conv_value[ID_W-1]);
        end else if (active) begin
            shift_bin <= shift_bin << 1;
            bcd       <= dabble_step(bcd, shift_bin[ID_W-1]);
        end
    end

    // the register holds its value once the shifting stops
    assign conv_digits = bcd;

endmodule

`default_nettype wire

/* range_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module range_walker
    import id_range_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       walk_start,
    input  range_t     walk_range,
    input  bcd_t       start_digits,
    output candidate_t cand
);

    logic walking;
    logic empty_slot;
    logic at_hi;
    id_t  cur_value;
    bcd_t cur_digits;

    // decimal increment with the carry rippling up through the nines
    function automatic bcd_t bcd_inc(input bcd_t d);
        bcd_t r;
        logic carry;
        r     = d;
        carry = 1'b1;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            if (carry) begin
                if (d[i] == 4'd9) begin
                    r[i] = 4'd0;
                end else begin
                    r[i]  = d[i] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return r;
    endfunction

    // the range stays latched in the controller for the whole walk
    assign at_hi = (cur_value == walk_range.hi);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            walking    <= 1'b0;
            empty_slot <= 1'b0;
        end else begin
            empty_slot <= 1'b0;
            if (walk_start) begin
                // an empty range never walks and only marks its end
                if (walk_range.lo > walk_range.hi) begin
                    empty_slot <= 1'b1;
                end else begin
                    walking <= 1'b1;
                end
            end else if (walking && at_hi) begin
                walking <= 1'b0;
            end
        end
    end

    // binary and decimal counters always step together
    always_ff @(posedge clk) begin
        if (walk_start) begin
            cur_value  <= walk_range.lo;
            cur_digits <= start_digits;
        end else if (walking && !at_hi) begin
            cur_value  <= cur_value + ID_W'(1);
            cur_digits <= bcd_inc(cur_digits);
        end
    end

    always_comb begin
        cand.valid  = walking;
        cand.last   = (walking && at_hi) || empty_slot;
        cand.value  = cur_value;
        cand.digits = cur_digits;
    end

endmodule

`default_nettype wire

/* repeat_detector.sv */
`timescale 1ns/1ps
`default_nettype none

module repeat_detector
    import id_range_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  candidate_t cand,
    output verdict_t   verdict
);

    logic [NDIG_W-1:0]     ndig;
    logic [MAX_DIGITS/2:1] period_hit;
    logic                  repeated;

    logic valid_q;
    logic last_q;
    logic invalid_q;
    id_t  value_q;

    // the digit count comes from the highest nonzero digit and zero has no digits at all
    always_comb begin
        ndig = '0;
        for (int i = 0; i < MAX_DIGITS; i++) begin
            if (cand.digits[i] != 4'd0) begin
                ndig = NDIG_W'(i + 1);
            end
        end
    end

    // period p needs at least two whole blocks, so a single digit never qualifies
    // every proper divisor of a count up to MAX_DIGITS is at most half of it
    always_comb begin
        period_hit = '0;
        for (int p = 1; p <= MAX_DIGITS / 2; p++) begin
            period_hit[p] = (int'(ndig) > p) && ((int'(ndig) % p) == 0);
            // the digits must match themselves shifted by p inside the used digits
            for (int i = 0; i + p < MAX_DIGITS; i++) begin
                if ((i + p < int'(ndig)) && (cand.digits[i] != cand.digits[i + p])) begin
                    period_hit[p] = 1'b0;
                end
            end
        end
    end

    assign repeated = |period_hit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= cand.valid;
            last_q  <= cand.last;
        end
    end

    always_ff @(posedge clk) begin
        invalid_q <= repeated;
        value_q   <= cand.value;
    end

    always_comb begin
        verdict.valid   = valid_q;
        verdict.last    = last_q;
        verdict.invalid = invalid_q;
        verdict.value   = value_q;
    end

endmodule

`default_nettype wire

/* scan_control.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_control
    import id_range_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  range_t             range_in,
    output logic               conv_start,
    output id_t                conv_value,
    input  logic               conv_done,
    input  bcd_t               conv_digits,
    output logic               walk_start,
    output range_t             walk_range,
    output bcd_t               start_digits,
    input  verdict_t           verdict,
    output logic               busy,
    output logic               done,
    output logic [SUM_W-1:0]   sum,
    output logic [COUNT_W-1:0] invalid_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_convert,
        st_walk
    } state_t;

    state_t state;
    logic   accept;

    // a start while busy is dropped
    assign accept = (state == st_idle) && start;

    // the converter takes lo straight from the input in the start cycle
    assign conv_start = accept;
    assign conv_value = range_in.lo;

    assign busy = (state != st_idle);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= st_idle;
            walk_start    <= 1'b0;
            done          <= 1'b0;
            sum           <= '0;
            invalid_count <= '0;
        end else begin
            walk_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        state         <= st_convert;
                        sum           <= '0;
                        invalid_count <= '0;
                    end
                end
                st_convert: begin
                    if (conv_done) begin
                        state      <= st_walk;
                        walk_start <= 1'b1;
                    end
                end
                st_walk: begin
                    if (verdict.valid && verdict.invalid) begin
                        sum           <= sum + SUM_W'(verdict.value);
                        invalid_count <= invalid_count + COUNT_W'(1);
                    end
                    // done rises with the last sum update already in place
                    if (verdict.last) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            walk_range <= range_in;
        end
        if ((state == st_convert) && conv_done) begin
            start_digits <= conv_digits;
        end
    end

endmodule

`default_nettype wire

/* id_range_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module id_range_scanner
    import id_range_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  range_t             range_in,
    output logic               busy,
    output logic               done,
    output logic [SUM_W-1:0]   sum,
    output logic [COUNT_W-1:0] invalid_count
);

    logic       conv_start;
    id_t        conv_value;
    logic       conv_done;
    bcd_t       conv_digits;
    logic       walk_start;
    range_t     walk_range;
    bcd_t       start_digits;
    candidate_t cand;
    verdict_t   verdict;

    scan_control u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .range_in     (range_in),
        .conv_start   (conv_start),
        .conv_value   (conv_value),
        .conv_done    (conv_done),
        .conv_digits  (conv_digits),
        .walk_start   (walk_start),
        .walk_range   (walk_range),
        .start_digits (start_digits),
        .verdict      (verdict),
        .busy         (busy),
        .done         (done),
        .sum          (sum),
        .invalid_count(invalid_count)
    );

    bin_to_bcd u_conv (
        .clk        (clk),
        .reset      (reset),
        .conv_start (conv_start),
        .conv_value (conv_value),
        .conv_done  (conv_done),
        .conv_digits(conv_digits)
    );

    range_walker u_walker (
        .clk         (clk),
        .reset       (reset),
        .walk_start  (walk_start),
        .walk_range  (walk_range),
        .start_digits(start_digits),
        .cand        (cand)
    );

    repeat_detector u_detect (
        .clk    (clk),
        .reset  (reset),
        .cand   (cand),
        .verdict(verdict)
    );

endmodule

`default_nettype wire

/* tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

`default_nettype none

// a number is a repeated block when it equals its first p digits written d/p times
function automatic logic is_repeated_id(input longint unsigned n);
    longint unsigned t;
    longint unsigned pow_p;
    longint unsigned block;
    longint unsigned rebuilt;
    int              d;
    logic            hit;
    d   = 0;
    t   = n;
    hit = 1'b0;
    while (t != 0) begin
        d = d + 1;
        t = t / 10;
    end
    for (int p = 1; p < d; p++) begin
        if ((d % p) == 0) begin
            pow_p = 1;
            for (int k = 0; k < p; k++) begin
                pow_p = pow_p * 10;
            end
            // drop the low d-p digits to keep the leading block
            block = n;
            for (int k = 0; k < d - p; k++) begin
                block = block / 10;
            end
            rebuilt = 0;
            for (int k = 0; k < d / p; k++) begin
                rebuilt = rebuilt * pow_p + block;
            end
            if (rebuilt == n) begin
                hit = 1'b1;
            end
        end
    end
    return hit;
endfunction

// sums and counts the repeated-block numbers from lo to hi and gives zero when lo > hi
function automatic void expected_range(input longint unsigned lo,
                                       input longint unsigned hi,
                                       output longint unsigned sum_out,
                                       output longint unsigned count_out);
    longint unsigned n;
    sum_out   = 0;
    count_out = 0;
    for (n = lo; n <= hi; n++) begin
        if (is_repeated_id(n)) begin
            sum_out   = sum_out + n;
            count_out = count_out + 1;
        end
    end
endfunction

`default_nettype wire

`endif

/* tb_id_range_scanner.sv */
`timescale 1ns/1ps
`include "tb_ref_model.svh"
`default_nettype none

module tb_id_range_scanner
    import id_range_pkg::*;
();

    typedef struct packed {
        id_t                lo;
        id_t                hi;
        logic [SUM_W-1:0]   sum;
        logic [COUNT_W-1:0] count;
    } scan_case_t;

    localparam longint unsigned ID_MAX         = 64'h0000_00FF_FFFF_FFFF;
    localparam longint unsigned FIRST_13_DIGIT = 64'd1000000000000;

    logic               clk;
    logic               reset;
    logic               start;
    range_t             range_in;
    logic               busy;
    logic               done;
    logic [SUM_W-1:0]   sum;
    logic [COUNT_W-1:0] invalid_count;

    scan_case_t      table_cases [0:6];
    int unsigned     seed_value;
    logic [63:0]     rnd;
    longint unsigned lo64;
    longint unsigned hi64;
    longint unsigned offset;
    longint unsigned exp_sum;
    longint unsigned exp_count;

    id_range_scanner dut_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .range_in     (range_in),
        .busy         (busy),
        .done         (done),
        .sum          (sum),
        .invalid_count(invalid_count)
    );

    always #4 clk = ~clk;

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic drive_start(input longint unsigned lo, input longint unsigned hi);
        @(negedge clk);
        start       = 1'b1;
        range_in.lo = id_t'(lo);
        range_in.hi = id_t'(hi);
        @(negedge clk);
        start = 1'b0;
    endtask

    // busy must stay high on every cycle before done when watch_busy is set
    task automatic wait_for_done(input int limit, input logic watch_busy);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (done) begin
                seen = 1'b1;
            end else if (watch_busy) begin
                compare_value("busy", 64'(busy), 64'd1);
            end
        end
        if (!seen) begin
            $display("timeout: done did not arrive within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "scan never finished");
        end
    endtask

    task automatic run_scan(input longint unsigned lo, input longint unsigned hi,
                            input longint unsigned want_sum,
                            input longint unsigned want_count);
        drive_start(lo, hi);
        wait_for_done(ID_W + 100, 1'b1);
        compare_value("busy", 64'(busy), 64'd0);
        compare_value("sum", sum, want_sum);
        compare_value("invalid_count", 64'(invalid_count), want_count);
    endtask

    // a number of at most 12 digits made of one random block written several times
    function automatic longint unsigned random_repeat_id();
        int unsigned     period;
        int unsigned     reps;
        longint unsigned pow_p;
        longint unsigned block;
        longint unsigned id;
        period = 1 + $urandom % 6;
        reps   = 2 + $urandom % (12 / period - 1);
        pow_p  = 1;
        for (int k = 0; k < int'(period); k++) begin
            pow_p = pow_p * 10;
        end
        block = pow_p / 10 + 64'($urandom) % (pow_p - pow_p / 10);
        id    = 0;
        for (int k = 0; k < int'(reps); k++) begin
            id = id * pow_p + block;
        end
        return id;
    endfunction

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        range_in   = '0;
        seed_value = $urandom(12037);

        table_cases[0] = '{40'd11, 40'd22, 64'd33, 40'd2};
        table_cases[1] = '{40'd95, 40'd115, 64'd210, 40'd2};
        table_cases[2] = '{40'd998, 40'd1012, 64'd2009, 40'd2};
        table_cases[3] = '{40'd1188511880, 40'd1188511890, 64'd1188511885, 40'd1};
        table_cases[4] = '{40'd5, 40'd9, 64'd0, 40'd0};
        table_cases[5] = '{40'd121212, 40'd121212, 64'd121212, 40'd1};
        // lo above hi gives an empty walk
        table_cases[6] = '{40'd50, 40'd40, 64'd0, 40'd0};

        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_value("busy", 64'(busy), 64'd0);
        compare_value("done", 64'(done), 64'd0);
        compare_value("sum", sum, 64'd0);
        compare_value("invalid_count", 64'(invalid_count), 64'd0);

        for (int i = 0; i <= 6; i++) begin
            run_scan(64'(table_cases[i].lo), 64'(table_cases[i].hi),
                     table_cases[i].sum, 64'(table_cases[i].count));
        end

        // even rounds land anywhere and odd rounds cover a known repeated block
        for (int i = 0; i < 20; i++) begin
            if ((i % 2) == 0) begin
                rnd  = {$urandom, $urandom};
                lo64 = 64'(rnd[ID_W-1:0]);
                // round zero stays among the 13-digit numbers
                if (i == 0) begin
                    lo64 = FIRST_13_DIGIT + lo64 % (ID_MAX - FIRST_13_DIGIT);
                end
                hi64 = lo64 + 64'($urandom % 64);
            end else begin
                lo64   = random_repeat_id();
                offset = 64'($urandom % 32);
                offset = (offset > lo64) ? lo64 : offset;
                lo64   = lo64 - offset;
                hi64   = lo64 + offset + 64'($urandom % (64 - offset));
            end
            if (hi64 > ID_MAX) begin
                hi64 = ID_MAX;
            end
            expected_range(lo64, hi64, exp_sum, exp_count);
            run_scan(lo64, hi64, exp_sum, exp_count);
        end

        // the second start lands in the middle of the first scan and is dropped
        drive_start(64'(table_cases[1].lo), 64'(table_cases[1].hi));
        repeat (5) @(negedge clk);
        compare_value("busy", 64'(busy), 64'd1);
        start       = 1'b1;
        range_in.lo = table_cases[0].lo;
        range_in.hi = table_cases[0].hi;
        @(negedge clk);
        start = 1'b0;
        wait_for_done(ID_W + 100, 1'b1);
        compare_value("sum", sum, table_cases[1].sum);
        compare_value("invalid_count", 64'(invalid_count), 64'(table_cases[1].count));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
id_range_pkg.sv
bin_to_bcd.sv
range_walker.sv
repeat_detector.sv
scan_control.sv
id_range_scanner.sv
tb_id_range_scanner.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it into sim.log and looks for the pass line

rm -f sim.log

verilator --binary --timing -f verilog.f --top-module tb_id_range_scanner \
    --Mdir obj_dir -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1

grep -qF '*** TEST PASSED ***' sim.log && echo "simulation ok" || { echo "simulation failed, see sim.log"; exit 1; }
